// ==== verilog/periph_params.svh ====
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// controller trigger pins on the console port
`define PERIPH_NUM_TRIG 4

// stable synchronized cycles before a debounced level flips
`define PERIPH_DEBOUNCE_CYCLES 4'd8
// debounce counter width
`define PERIPH_CNT_W 4

// apb bus widths
`define PERIPH_ADDR_W 8
`define PERIPH_DATA_W 8

// register offsets on the apb bus
`define PERIPH_REG_CTRL   8'h00
`define PERIPH_REG_RELOAD 8'h04
`define PERIPH_REG_STATUS 8'h08
`define PERIPH_REG_TRIG   8'h0C
`define PERIPH_REG_COUNT  8'h10

`endif

// ==== verilog/periphPkg.sv ====
`default_nettype none

`include "periph_params.svh"

package periphPkg;

    // one data word on the register bus
    typedef logic [`PERIPH_DATA_W-1:0] byte_t;

    // one bit per controller trigger
    typedef logic [`PERIPH_NUM_TRIG-1:0] trigVec_t;

    // timer prescale select, clock divided by 1, 4, 16 or 64
    typedef enum logic [1:0] {
        DIV1  = 2'd0,
        DIV4  = 2'd1,
        DIV16 = 2'd2,
        DIV64 = 2'd3
    } prescale_e;

    // register offsets as seen on paddr
    typedef enum logic [`PERIPH_ADDR_W-1:0] {
        REG_CTRL   = `PERIPH_REG_CTRL,
        REG_RELOAD = `PERIPH_REG_RELOAD,
        REG_STATUS = `PERIPH_REG_STATUS,
        REG_TRIG   = `PERIPH_REG_TRIG,
        REG_COUNT  = `PERIPH_REG_COUNT
    } regAddr_e;

endpackage

`default_nettype wire

// ==== verilog/triggerDebounce.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_params.svh"

module triggerDebounce (
    input  logic               inClk,
    input  logic               rstN,
    // raw pins straight from the controller port
    input  periphPkg::trigVec_t trigPins,
    // filtered levels
    output periphPkg::trigVec_t trigLevel,
    // one cycle pulse per bit on a filtered press
    output periphPkg::trigVec_t trigPress
);

    // two flop synchronizer stages
    periphPkg::trigVec_t syncA;
    periphPkg::trigVec_t syncB;

    // one stability counter per trigger
    logic [`PERIPH_CNT_W-1:0] stableCnt [`PERIPH_NUM_TRIG];

    // pins are asynchronous to inClk
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            syncA <= '0;
            syncB <= '0;
        end else begin
            syncA <= trigPins;
            syncB <= syncA;
        end
    end

    // per bit filter
    // counter runs only while the synchronized input disagrees with the level
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            trigLevel <= '0;
            trigPress <= '0;
            for (int i = 0; i < `PERIPH_NUM_TRIG; i++) begin
                stableCnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PERIPH_NUM_TRIG; i++) begin
                // press pulse lasts one cycle by default
                trigPress[i] <= 1'b0;
                if (syncB[i] == trigLevel[i]) begin
                    // any return to the old level restarts the filter
                    stableCnt[i] <= '0;
                end else if (stableCnt[i] == `PERIPH_DEBOUNCE_CYCLES - 1'b1) begin
                    // enough disagreeing cycles so accept the new level
                    trigLevel[i] <= syncB[i];
                    stableCnt[i] <= '0;
                    // release is filtered too but only a rise flags a press
                    trigPress[i] <= syncB[i];
                end else begin
                    stableCnt[i] <= stableCnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/intervalTimer.sv ====
`timescale 1ns/1ns
`default_nettype none

module intervalTimer (
    input  logic                 inClk,
    input  logic                 rstN,
    // run control from CTRL
    input  logic                 timerEnable,
    input  periphPkg::prescale_e prescale,
    // reload value from RELOAD
    input  periphPkg::byte_t     reload,
    // load strobe from the register block
    input  logic                 reloadLoad,
    // live count for the COUNT register
    output periphPkg::byte_t     count,
    // one cycle pulse when a tick hits zero
    output logic                 expire
);

    // prescaler counter, wide enough for divide by 64
    logic [5:0] preCnt;
    // terminal value of the prescaler for the selected divide
    logic [5:0] preMax;
    // clock enable for the down counter
    logic       tick;

    // divide select
    always_comb begin
        case (prescale)
            periphPkg::DIV1:  preMax = 6'd0;
            periphPkg::DIV4:  preMax = 6'd3;
            periphPkg::DIV16: preMax = 6'd15;
            periphPkg::DIV64: preMax = 6'd63;
            default:          preMax = 6'd0;
        endcase
    end

    // tick once every preMax+1 enabled cycles
    assign tick = timerEnable && (preCnt == preMax);

    // prescaler
    // a load restarts the divide so the first period is a full one
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            preCnt <= '0;
        end else if (reloadLoad || !timerEnable) begin
            // idle timer keeps the prescaler cleared
            preCnt <= '0;
        end else if (tick) begin
            preCnt <= '0;
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    // down counter
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (reloadLoad) begin
            count <= reload;
        end else if (tick) begin
            if (count == '0) begin
                // period done, start again from the reload value
                count <= reload;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // registered expiry pulse
    // lands (reload+1)*div cycles after the load
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            expire <= 1'b0;
        end else begin
            expire <= tick && !reloadLoad && (count == '0);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/apbRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_params.svh"

module apbRegs (
    input  logic                      inClk,
    input  logic                      rstN,
    // apb slave side
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`PERIPH_ADDR_W-1:0] paddr,
    input  periphPkg::byte_t          pwdata,
    output periphPkg::byte_t          prdata,
    output logic                      pready,
    output logic                      pslverr,
    // from the debouncer
    input  periphPkg::trigVec_t       trigLevel,
    input  periphPkg::trigVec_t       trigPress,
    // from the timer
    input  periphPkg::byte_t          count,
    input  logic                      expire,
    // to the timer
    output logic                      timerEnable,
    output periphPkg::prescale_e      prescale,
    output periphPkg::byte_t          reload,
    output logic                      reloadLoad,
    // interrupt line
    output logic                      irq
);

    // register storage
    periphPkg::byte_t ctrlReg;
    periphPkg::byte_t reloadReg;
    periphPkg::byte_t statusReg;

    // decoded bus address
    periphPkg::regAddr_e regAddr;
    // access phase of a transfer
    logic               access;
    // bad address or write to a read only register
    logic               accErr;
    // read mux output
    periphPkg::byte_t   rdData;
    // write commit strobe in the pready cycle
    logic               wrEn;

    // status set and clear vectors
    periphPkg::byte_t   statusSet;
    periphPkg::byte_t   statusClr;
    // enables lined up with STATUS bit positions
    periphPkg::byte_t   irqMask;

    assign regAddr = periphPkg::regAddr_e'(paddr);
    assign access  = psel && penable;

    // address decode and read mux
    // unmapped reads return zero
    always_comb begin
        rdData = '0;
        accErr = 1'b0;
        case (regAddr)
            periphPkg::REG_CTRL:   rdData = ctrlReg;
            periphPkg::REG_RELOAD: rdData = reloadReg;
            periphPkg::REG_STATUS: rdData = statusReg;
            periphPkg::REG_TRIG: begin
                rdData = periphPkg::byte_t'(trigLevel);
                accErr = pwrite;
            end
            periphPkg::REG_COUNT: begin
                rdData = count;
                accErr = pwrite;
            end
            default: accErr = 1'b1;
        endcase
    end

    // writes commit at the edge that ends the pready cycle
    assign wrEn = access && pready && pwrite && !accErr;

    // one wait state
    // pready and the response are registered at the end of the first access cycle
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            pready  <= access && !pready;
            pslverr <= access && !pready && accErr;
            if (access && !pready && !pwrite && !accErr) begin
                prdata <= rdData;
            end else begin
                prdata <= '0;
            end
        end
    end

    // CTRL and RELOAD
    // reload strobe also fires when the enable goes from 0 to 1
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            ctrlReg    <= '0;
            reloadReg  <= '0;
            reloadLoad <= 1'b0;
        end else begin
            reloadLoad <= 1'b0;
            if (wrEn && regAddr == periphPkg::REG_CTRL) begin
                ctrlReg    <= pwdata;
                reloadLoad <= pwdata[0] && !ctrlReg[0];
            end
            if (wrEn && regAddr == periphPkg::REG_RELOAD) begin
                reloadReg  <= pwdata;
                reloadLoad <= 1'b1;
            end
        end
    end

    // events land in bit 0 and bits 7:4
    assign statusSet = {trigPress, 3'b000, expire};
    // write one to clear
    assign statusClr = (wrEn && regAddr == periphPkg::REG_STATUS) ? pwdata : '0;

    // sticky status, a same cycle set beats the clear
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            statusReg <= '0;
        end else begin
            statusReg <= (statusReg & ~statusClr) | statusSet;
        end
    end

    // trigger enables over bits 7:4 and timer enable over bit 0
    assign irqMask = {ctrlReg[7:4], 3'b000, ctrlReg[3]};

    // irq follows STATUS and CTRL one cycle later
    always_ff @(posedge inClk or negedge rstN) begin
        if (!rstN) begin
            irq <= 1'b0;
        end else begin
            irq <= |(statusReg & irqMask);
        end
    end

    // timer controls straight from CTRL and RELOAD
    assign timerEnable = ctrlReg[0];
    assign prescale    = periphPkg::prescale_e'(ctrlReg[2:1]);
    assign reload      = reloadReg;

endmodule

`default_nettype wire

// ==== verilog/periphTop.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_params.svh"

module periphTop (
    input  logic                      inClk,
    input  logic                      rstN,
    // apb slave port
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`PERIPH_ADDR_W-1:0] paddr,
    input  periphPkg::byte_t          pwdata,
    output periphPkg::byte_t          prdata,
    output logic                      pready,
    output logic                      pslverr,
    // raw controller triggers
    input  periphPkg::trigVec_t       trigPins,
    // interrupt to the cpu
    output logic                      irq
);

    // debouncer results
    periphPkg::trigVec_t  trigLevel;
    periphPkg::trigVec_t  trigPress;
    // timer controls
    logic                 timerEnable;
    periphPkg::prescale_e prescale;
    periphPkg::byte_t     reload;
    logic                 reloadLoad;
    // timer results
    periphPkg::byte_t     count;
    logic                 expire;

    // trigger filtering
    triggerDebounce i_trigDebounce (
        .inClk     (inClk),
        .rstN      (rstN),
        .trigPins  (trigPins),
        .trigLevel (trigLevel),
        .trigPress (trigPress)
    );

    // interval timer on a clock enable
    intervalTimer i_timer (
        .inClk       (inClk),
        .rstN        (rstN),
        .timerEnable (timerEnable),
        .prescale    (prescale),
        .reload      (reload),
        .reloadLoad  (reloadLoad),
        .count       (count),
        .expire      (expire)
    );

    // register slave and interrupt
    apbRegs i_regs (
        .inClk       (inClk),
        .rstN        (rstN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .trigLevel   (trigLevel),
        .trigPress   (trigPress),
        .count       (count),
        .expire      (expire),
        .timerEnable (timerEnable),
        .prescale    (prescale),
        .reload      (reload),
        .reloadLoad  (reloadLoad),
        .irq         (irq)
    );

endmodule

`default_nettype wire

// ==== sim/periphTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_params.svh"

module periphTb;

    // one apb transfer takes four clock cycles
    localparam int XFER_CYC     = 4;
    localparam int REG_OPS      = 40;
    localparam int DEB_ROUNDS   = 16;
    localparam int CLR_ROUNDS   = 8;
    localparam int TIMER_ROUNDS = 3;
    localparam int IRQ_ROUNDS   = 8;
    // worst case cycles of all tests together
    localparam int TEST_CYC = (5 + 3 * REG_OPS) * XFER_CYC
                            + DEB_ROUNDS * (28 + 3 * XFER_CYC)
                            + CLR_ROUNDS * (20 + 3 * XFER_CYC)
                            + TIMER_ROUNDS * (32 * 64 + 10 * XFER_CYC)
                            + IRQ_ROUNDS * (24 + 2 * XFER_CYC) + 80;
    localparam int WATCHDOG_CYC = 2 * TEST_CYC + 1000;

    logic                      inClk;
    logic                      rstN;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`PERIPH_ADDR_W-1:0] paddr;
    periphPkg::byte_t          pwdata;
    periphPkg::byte_t          prdata;
    logic                      pready;
    logic                      pslverr;
    periphPkg::trigVec_t       trigPins;
    logic                      irq;

    // reference model state
    periphPkg::byte_t    modelCtrl;
    periphPkg::byte_t    modelReload;
    periphPkg::byte_t    modelStatus;
    periphPkg::byte_t    modelCount;
    periphPkg::trigVec_t modelLevel;

    // rising edges seen since time zero
    int cycleCnt = 0;
    // edge on which the last transfer committed
    int lastCommitCyc;

    periphTop i_dut (
        .inClk   (inClk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .trigPins(trigPins),
        .irq     (irq)
    );

    always #5 inClk = ~inClk;

    always @(posedge inClk) cycleCnt <= cycleCnt + 1;

    task automatic reportFailure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkByte(input string name, input periphPkg::byte_t got,
                             input periphPkg::byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            reportFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            reportFailure();
        end
    endtask

    function automatic logic isMapped(input logic [`PERIPH_ADDR_W-1:0] addr);
        case (addr)
            `PERIPH_REG_CTRL, `PERIPH_REG_RELOAD, `PERIPH_REG_STATUS,
            `PERIPH_REG_TRIG, `PERIPH_REG_COUNT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // unmapped offsets and writes to the read only registers are refused
    function automatic logic expectErr(input logic [`PERIPH_ADDR_W-1:0] addr, input logic wr);
        return !isMapped(addr) ||
               (wr && (addr == `PERIPH_REG_TRIG || addr == `PERIPH_REG_COUNT));
    endfunction

    // timer expiry pairs with CTRL bit 3 and each press bit with its own enable
    function automatic logic expectIrq();
        logic timerIrq;
        logic trigIrq;
        timerIrq = modelStatus[0] && modelCtrl[3];
        trigIrq  = |(modelStatus[7:4] & modelCtrl[7:4]);
        return timerIrq || trigIrq;
    endfunction

    // prescale codes 0..3 divide by 1, 4, 16, 64
    function automatic int divOf(input logic [1:0] sel);
        return 1 << (2 * sel);
    endfunction

    task automatic waitCycle(input int target);
        while (cycleCnt < target) @(negedge inClk);
    endtask

    // one transfer with exactly one wait state
    task automatic apbXfer(input logic wr, input logic [`PERIPH_ADDR_W-1:0] addr,
                           input periphPkg::byte_t wdata, output periphPkg::byte_t rdata,
                           output logic err);
        @(negedge inClk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge inClk);
        penable = 1'b1;
        // first access cycle is the wait state
        checkBit("pready", pready, 1'b0);
        @(negedge inClk);
        checkBit("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(negedge inClk);
        psel    = 1'b0;
        penable = 1'b0;
        // the write took effect on the edge just passed
        lastCommitCyc = cycleCnt;
    endtask

    task automatic writeReg(input logic [`PERIPH_ADDR_W-1:0] addr, input periphPkg::byte_t data);
        periphPkg::byte_t rdata;
        logic             err;
        logic             expErr;
        expErr = expectErr(addr, 1'b1);
        apbXfer(1'b1, addr, data, rdata, err);
        checkBit("pslverr", err, expErr);
        if (expErr) begin
            checkByte("prdata", rdata, 8'h00);
        end else begin
            case (addr)
                `PERIPH_REG_CTRL: modelCtrl = data;
                `PERIPH_REG_RELOAD: begin
                    // a reload write also loads the count
                    modelReload = data;
                    modelCount  = data;
                end
                `PERIPH_REG_STATUS: modelStatus = modelStatus & ~data;
                default: ;
            endcase
        end
    endtask

    task automatic readReg(input logic [`PERIPH_ADDR_W-1:0] addr, input periphPkg::byte_t expData);
        periphPkg::byte_t rdata;
        logic             err;
        logic             expErr;
        expErr = expectErr(addr, 1'b0);
        apbXfer(1'b0, addr, 8'h00, rdata, err);
        checkBit("pslverr", err, expErr);
        checkByte("prdata", rdata, expErr ? 8'h00 : expData);
    endtask

    task automatic holdPins(input periphPkg::trigVec_t pins, input int cycles);
        @(negedge inClk);
        trigPins = pins;
        repeat (cycles - 1) @(negedge inClk);
    endtask

    // hold long enough for the filter to accept the new level
    task automatic settlePins(input periphPkg::trigVec_t pins);
        int holdLen;
        holdLen = `PERIPH_DEBOUNCE_CYCLES + 5 + $urandom % 6;
        holdPins(pins, holdLen);
        modelStatus[7:4] = modelStatus[7:4] | (pins & ~modelLevel);
        modelLevel       = pins;
    endtask

    task automatic regMapTest();
        logic [`PERIPH_ADDR_W-1:0] badAddr;
        periphPkg::byte_t          data;
        int                        op;
        // all registers clear out of reset
        readReg(`PERIPH_REG_CTRL, 8'h00);
        readReg(`PERIPH_REG_RELOAD, 8'h00);
        readReg(`PERIPH_REG_STATUS, 8'h00);
        readReg(`PERIPH_REG_TRIG, 8'h00);
        readReg(`PERIPH_REG_COUNT, 8'h00);
        for (int i = 0; i < REG_OPS; i++) begin
            op   = $urandom % 5;
            data = $urandom;
            case (op)
                0: begin
                    // timer stays off here
                    writeReg(`PERIPH_REG_CTRL, data & 8'hFE);
                    readReg(`PERIPH_REG_CTRL, modelCtrl);
                end
                1: begin
                    writeReg(`PERIPH_REG_RELOAD, data);
                    readReg(`PERIPH_REG_RELOAD, modelReload);
                    readReg(`PERIPH_REG_COUNT, modelCount);
                end
                2: begin
                    do begin
                        badAddr = $urandom;
                    end while (isMapped(badAddr));
                    if (data[0]) begin
                        writeReg(badAddr, data);
                    end else begin
                        readReg(badAddr, 8'h00);
                    end
                end
                3: writeReg(data[0] ? `PERIPH_REG_TRIG : `PERIPH_REG_COUNT, data);
                default: begin
                    // refused writes must not leak into any register
                    readReg(`PERIPH_REG_CTRL, modelCtrl);
                    readReg(`PERIPH_REG_RELOAD, modelReload);
                    readReg(`PERIPH_REG_STATUS, modelStatus);
                end
            endcase
        end
    endtask

    task automatic debounceTest();
        periphPkg::trigVec_t mask;
        int                  glitchLen;
        for (int i = 0; i < DEB_ROUNDS; i++) begin
            // short excursion on a nonzero set of pins
            mask      = 1 + $urandom % ((1 << `PERIPH_NUM_TRIG) - 1);
            glitchLen = 1 + $urandom % (`PERIPH_DEBOUNCE_CYCLES - 1);
            holdPins(modelLevel ^ mask, glitchLen);
            holdPins(modelLevel, 3);
            readReg(`PERIPH_REG_TRIG, periphPkg::byte_t'(modelLevel));
            settlePins($urandom);
            readReg(`PERIPH_REG_TRIG, periphPkg::byte_t'(modelLevel));
            readReg(`PERIPH_REG_STATUS, modelStatus);
        end
    endtask

    task automatic pressClearTest();
        periphPkg::byte_t mask;
        for (int i = 0; i < CLR_ROUNDS; i++) begin
            settlePins($urandom);
            readReg(`PERIPH_REG_STATUS, modelStatus);
            mask = $urandom;
            writeReg(`PERIPH_REG_STATUS, mask);
            readReg(`PERIPH_REG_STATUS, modelStatus);
        end
    endtask

    task automatic timerTest();
        periphPkg::byte_t reloadVal;
        logic [1:0]       presc;
        int               period;
        int               loadCyc;
        int               ticks;
        for (int i = 0; i < TIMER_ROUNDS; i++) begin
            reloadVal = 3 + $urandom % 29;
            presc     = $urandom;
            period    = (reloadVal + 1) * divOf(presc);
            writeReg(`PERIPH_REG_RELOAD, reloadVal);
            // timer interrupt enable alternates between rounds
            writeReg(`PERIPH_REG_CTRL, {4'h0, i[0], presc, 1'b1});
            // count loads one edge after the enabling write
            loadCyc = lastCommitCyc + 1;
            // a read samples STATUS as of two edges after its start
            waitCycle(lastCommitCyc + period - 4);
            readReg(`PERIPH_REG_STATUS, modelStatus);
            waitCycle(loadCyc - 1 + period);
            modelStatus[0] = 1'b1;
            readReg(`PERIPH_REG_STATUS, modelStatus);
            checkBit("irq", irq, expectIrq());
            writeReg(`PERIPH_REG_CTRL, modelCtrl & 8'hFE);
            // ticks up to and including the stopping edge still count
            ticks      = (lastCommitCyc - loadCyc) / divOf(presc);
            modelCount = reloadVal - ticks % (reloadVal + 1);
            readReg(`PERIPH_REG_COUNT, modelCount);
            repeat (2) @(negedge inClk);
            writeReg(`PERIPH_REG_STATUS, 8'h01);
            readReg(`PERIPH_REG_STATUS, modelStatus);
            checkBit("irq", irq, expectIrq());
        end
    endtask

    task automatic irqTest();
        periphPkg::byte_t data;
        for (int i = 0; i < IRQ_ROUNDS; i++) begin
            settlePins($urandom);
            checkBit("irq", irq, expectIrq());
            data = $urandom;
            writeReg(`PERIPH_REG_CTRL, data & 8'hFE);
            repeat (2) @(negedge inClk);
            checkBit("irq", irq, expectIrq());
            data = $urandom;
            writeReg(`PERIPH_REG_STATUS, data);
            repeat (2) @(negedge inClk);
            checkBit("irq", irq, expectIrq());
        end
        // every trigger enabled and every press bit set
        writeReg(`PERIPH_REG_CTRL, 8'hF8);
        settlePins('0);
        settlePins('1);
        repeat (2) @(negedge inClk);
        checkBit("irq", irq, expectIrq());
        writeReg(`PERIPH_REG_STATUS, 8'hFF);
        repeat (2) @(negedge inClk);
        checkBit("irq", irq, 1'b0);
    endtask

    initial begin
        inClk       = 1'b0;
        rstN        = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        trigPins    = '0;
        modelCtrl   = '0;
        modelReload = '0;
        modelStatus = '0;
        modelCount  = '0;
        modelLevel  = '0;
        void'($urandom(85902));
        repeat (4) @(negedge inClk);
        rstN = 1'b1;
        regMapTest();
        debounceTest();
        pressClearTest();
        timerTest();
        irqTest();
        $display("All tests passed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYC) @(posedge inClk);
        $display("run timed out after %0d clock cycles", WATCHDOG_CYC);
        reportFailure();
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/periphPkg.sv
verilog/triggerDebounce.sv
verilog/intervalTimer.sv
verilog/apbRegs.sv
verilog/periphTop.sv
sim/periphTb.sv
